//--- design/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ##########################################################################
// Cache geometry.
// ##########################################################################

`define CACHE_OFFSET_W 5
`define CACHE_INDEX_W  4
`define CACHE_TAG_W    23
`define CACHE_WAYS     4
`define CACHE_SETS     16
`define CACHE_LINE_W   256   // Bits per line.
`define CACHE_MASK_W   32    // One enable per byte.

// ##########################################################################
// APB register map.
// ##########################################################################

`define CACHE_REG_CTRL   32'h0000_0000
`define CACHE_REG_HITS   32'h0000_0004
`define CACHE_REG_MISSES 32'h0000_0008
`define CACHE_REG_WBACKS 32'h0000_000C

`endif

//--- design/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    // Data array write source.
    typedef enum logic {
        DATA_SRC_CPU = 1'b0,   // CPU data under byte enable.
        DATA_SRC_MEM = 1'b1    // Memory line, all bytes.
    } data_src_e;

    // Target way for data, dirty and PLRU updates.
    typedef enum logic {
        WAY_HIT    = 1'b0,
        WAY_VICTIM = 1'b1
    } way_sel_e;

    typedef enum logic {
        PMEM_ADDR_CPU    = 1'b0,  // CPU line address.
        PMEM_ADDR_VICTIM = 1'b1   // Victim tag with current index.
    } pmem_addr_sel_e;

    typedef enum logic {
        RDATA_WAY  = 1'b0,
        RDATA_PMEM = 1'b1
    } rdata_sel_e;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_fields_t;

    // CPU address, raw or split.
    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_u;

endpackage

//--- design/cache_data_array.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_data_array (
    input  logic                       clk,
    input  logic                       we,
    input  logic [`CACHE_MASK_W-1:0]   wmask,
    input  logic [`CACHE_INDEX_W-1:0]  index,
    input  logic [`CACHE_LINE_W-1:0]   wdata,
    output logic [`CACHE_LINE_W-1:0]   rdata
);

    logic [`CACHE_LINE_W-1:0] mem [`CACHE_SETS];

    // Byte-masked write.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < `CACHE_MASK_W; b++) begin
                if (wmask[b]) begin
                    mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read returns the old line on a same-cycle write.
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

//--- design/cache_datapath.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_datapath (
    input  logic                            clk,
    input  logic                            rst,

    input  logic [31:0]                     mem_address,
    input  logic [`CACHE_MASK_W-1:0]        mem_byte_enable,
    input  logic [`CACHE_LINE_W-1:0]        mem_wdata,
    output logic [`CACHE_LINE_W-1:0]        mem_rdata,

    output logic [31:0]                     pmem_address,
    output logic [`CACHE_LINE_W-1:0]        pmem_wdata,
    input  logic [`CACHE_LINE_W-1:0]        pmem_rdata,

    input  logic                            ld_tag,
    input  logic                            ld_valid,
    input  logic                            ld_dirty,
    input  logic                            ld_data,
    input  logic                            ld_plru,
    input  logic                            dirty_val,
    input  cache_pkg::data_src_e            data_src,
    input  cache_pkg::way_sel_e             data_way,
    input  cache_pkg::way_sel_e             dirty_way,
    input  cache_pkg::way_sel_e             plru_way,
    input  cache_pkg::pmem_addr_sel_e       pmem_addr_sel,
    input  cache_pkg::rdata_sel_e           rdata_sel,

    output logic                            hit,
    output logic                            victim_dirty
);

    cache_pkg::cache_addr_u addr;
    cache_pkg::cache_addr_u line_addr;
    cache_pkg::cache_addr_u wb_addr;

    logic [`CACHE_TAG_W-1:0]   tag_q   [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]    valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]    dirty_q [`CACHE_SETS];
    logic [2:0]                plru_q  [`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0]  way_rdata [`CACHE_WAYS];

    logic [`CACHE_WAYS-1:0]    hit_vec;
    logic [1:0]                hit_way;
    logic [1:0]                victim_way;
    logic [1:0]                data_target;
    logic [1:0]                dirty_target;
    logic [1:0]                plru_target;
    logic [2:0]                plru_cur;

    assign addr.raw = mem_address;

    // ######################################################################
    // Hit detection and victim choice.
    // ######################################################################

    always_comb begin
        hit_vec = '0;
        hit_way = 2'd0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_q[addr.f.index][w] && (tag_q[w][addr.f.index] == addr.f.tag);
            if (hit_vec[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    assign hit = |hit_vec;

    assign plru_cur = plru_q[addr.f.index];

    always_comb begin
        if (plru_cur[0]) begin
            victim_way = plru_cur[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = plru_cur[2] ? 2'd2 : 2'd3;
        end
    end

    assign victim_dirty = valid_q[addr.f.index][victim_way] & dirty_q[addr.f.index][victim_way];

    assign data_target  = (data_way  == cache_pkg::WAY_VICTIM) ? victim_way : hit_way;
    assign dirty_target = (dirty_way == cache_pkg::WAY_VICTIM) ? victim_way : hit_way;
    assign plru_target  = (plru_way  == cache_pkg::WAY_VICTIM) ? victim_way : hit_way;

    // ######################################################################
    // State arrays.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (ld_tag) begin
            tag_q[victim_way][addr.f.index] <= addr.f.tag;  // Fills land in the victim.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= 3'b000;
            end
        end else begin
            if (ld_valid) begin
                valid_q[addr.f.index][victim_way] <= 1'b1;
            end
            if (ld_dirty) begin
                dirty_q[addr.f.index][dirty_target] <= dirty_val;
            end
            if (ld_plru) begin
                case (plru_target)
                    2'd0:    plru_q[addr.f.index] <= {plru_cur[2], 1'b0, 1'b0};
                    2'd1:    plru_q[addr.f.index] <= {plru_cur[2], 1'b1, 1'b0};
                    2'd2:    plru_q[addr.f.index] <= {1'b0, plru_cur[1], 1'b1};
                    default: plru_q[addr.f.index] <= {1'b1, plru_cur[1], 1'b1};
                endcase
            end
        end
    end

    // ######################################################################
    // Line storage and muxing.
    // ######################################################################

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        cache_data_array data_array_i (
            .clk   (clk),
            .we    (ld_data && (data_target == 2'(i))),
            .wmask ((data_src == cache_pkg::DATA_SRC_MEM) ? {`CACHE_MASK_W{1'b1}} : mem_byte_enable),
            .index (addr.f.index),
            .wdata ((data_src == cache_pkg::DATA_SRC_MEM) ? pmem_rdata : mem_wdata),
            .rdata (way_rdata[i])
        );
    end

    always_comb begin
        line_addr          = addr;
        line_addr.f.offset = '0;
        wb_addr            = '0;
        wb_addr.f.tag      = tag_q[victim_way][addr.f.index];
        wb_addr.f.index    = addr.f.index;
    end

    assign pmem_address = (pmem_addr_sel == cache_pkg::PMEM_ADDR_VICTIM) ? wb_addr.raw
                                                                          : line_addr.raw;
    assign pmem_wdata   = way_rdata[victim_way];
    assign mem_rdata    = (rdata_sel == cache_pkg::RDATA_PMEM) ? pmem_rdata : way_rdata[hit_way];

endmodule

//--- design/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            mem_read,
    input  logic                            mem_write,
    output logic                            mem_resp,

    output logic                            pmem_read,
    output logic                            pmem_write,
    input  logic                            pmem_resp,

    input  logic                            hit,
    input  logic                            victim_dirty,

    output logic                            ld_tag,
    output logic                            ld_valid,
    output logic                            ld_dirty,
    output logic                            ld_data,
    output logic                            ld_plru,
    output logic                            dirty_val,
    output cache_pkg::data_src_e            data_src,
    output cache_pkg::way_sel_e             data_way,
    output cache_pkg::way_sel_e             dirty_way,
    output cache_pkg::way_sel_e             plru_way,
    output cache_pkg::pmem_addr_sel_e       pmem_addr_sel,
    output cache_pkg::rdata_sel_e           rdata_sel,

    output logic                            hit_evt,
    output logic                            miss_evt,
    output logic                            wback_evt
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETTLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL,
        ST_REFILL
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   missed_q;   // Current request already counted as a miss.

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            missed_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_COMPARE) begin
                missed_q <= !hit;
            end
        end
    end

    // ######################################################################
    // Next state and outputs.
    // ######################################################################

    always_comb begin
        state_d       = state_q;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        ld_tag        = 1'b0;
        ld_valid      = 1'b0;
        ld_dirty      = 1'b0;
        ld_data       = 1'b0;
        ld_plru       = 1'b0;
        dirty_val     = 1'b0;
        data_src      = cache_pkg::DATA_SRC_CPU;
        data_way      = cache_pkg::WAY_HIT;
        dirty_way     = cache_pkg::WAY_HIT;
        plru_way      = cache_pkg::WAY_HIT;
        pmem_addr_sel = cache_pkg::PMEM_ADDR_CPU;
        rdata_sel     = cache_pkg::RDATA_WAY;
        hit_evt       = 1'b0;
        miss_evt      = 1'b0;
        wback_evt     = 1'b0;

        unique case (state_q)
            ST_IDLE: begin
                if (mem_read || mem_write) begin
                    state_d = ST_SETTLE;
                end
            end
            ST_SETTLE: state_d = ST_COMPARE;   // Arrays read this cycle.
            ST_COMPARE: begin
                if (hit) begin
                    mem_resp = 1'b1;
                    ld_plru  = 1'b1;
                    hit_evt  = !missed_q;
                    if (mem_write) begin
                        ld_data   = 1'b1;
                        ld_dirty  = 1'b1;
                        dirty_val = 1'b1;
                    end
                    state_d = ST_IDLE;
                end else begin
                    miss_evt  = !missed_q;
                    wback_evt = victim_dirty;
                    state_d   = victim_dirty ? ST_WRITEBACK : ST_FILL;
                end
            end
            ST_WRITEBACK: begin
                pmem_write    = 1'b1;
                pmem_addr_sel = cache_pkg::PMEM_ADDR_VICTIM;
                if (pmem_resp) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                pmem_read = 1'b1;
                rdata_sel = cache_pkg::RDATA_PMEM;
                if (pmem_resp) begin
                    // Install the line clean in the victim way.
                    ld_tag    = 1'b1;
                    ld_valid  = 1'b1;
                    ld_data   = 1'b1;
                    ld_dirty  = 1'b1;
                    ld_plru   = 1'b1;
                    data_src  = cache_pkg::DATA_SRC_MEM;
                    data_way  = cache_pkg::WAY_VICTIM;
                    dirty_way = cache_pkg::WAY_VICTIM;
                    plru_way  = cache_pkg::WAY_VICTIM;
                    state_d   = ST_REFILL;
                end
            end
            ST_REFILL: state_d = ST_COMPARE;
            default:   state_d = ST_IDLE;
        endcase
    end

endmodule

//--- design/cache_apb_regs.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_apb_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    input  logic        hit_evt,
    input  logic        miss_evt,
    input  logic        wback_evt
);

    logic        count_en;
    logic        ctrl_wr;
    logic        clear;
    logic [2:0]  evt;
    logic [31:0] cnt_q [3];   // Hits, misses, write-backs.

    // Writes land at the end of the access phase.
    assign ctrl_wr = psel && penable && pwrite && (paddr == `CACHE_REG_CTRL);
    assign clear   = ctrl_wr && pwdata[1];
    assign evt     = {wback_evt, miss_evt, hit_evt};

    always_ff @(posedge clk) begin
        if (rst) begin
            count_en <= 1'b1;
        end else if (ctrl_wr) begin
            count_en <= pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < 3; c++) begin
                cnt_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < 3; c++) begin
                if (clear) begin
                    cnt_q[c] <= '0;   // Clear beats a same-cycle event.
                end else if (count_en && evt[c]) begin
                    cnt_q[c] <= cnt_q[c] + 32'd1;
                end
            end
        end
    end

    // Read mux. Clear bit always reads as zero.
    always_comb begin
        case (paddr)
            `CACHE_REG_CTRL:   prdata = {31'd0, count_en};
            `CACHE_REG_HITS:   prdata = cnt_q[0];
            `CACHE_REG_MISSES: prdata = cnt_q[1];
            `CACHE_REG_WBACKS: prdata = cnt_q[2];
            default:           prdata = 32'd0;
        endcase
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [31:0]                 mem_address,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic [`CACHE_MASK_W-1:0]    mem_byte_enable,
    input  logic [`CACHE_LINE_W-1:0]    mem_wdata,
    output logic [`CACHE_LINE_W-1:0]    mem_rdata,
    output logic                        mem_resp,

    output logic [31:0]                 pmem_address,
    output logic                        pmem_read,
    output logic                        pmem_write,
    output logic [`CACHE_LINE_W-1:0]    pmem_wdata,
    input  logic [`CACHE_LINE_W-1:0]    pmem_rdata,
    input  logic                        pmem_resp,

    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata
);

    logic                        hit;
    logic                        victim_dirty;
    logic                        ld_tag;
    logic                        ld_valid;
    logic                        ld_dirty;
    logic                        ld_data;
    logic                        ld_plru;
    logic                        dirty_val;
    cache_pkg::data_src_e        data_src;
    cache_pkg::way_sel_e         data_way;
    cache_pkg::way_sel_e         dirty_way;
    cache_pkg::way_sel_e         plru_way;
    cache_pkg::pmem_addr_sel_e   pmem_addr_sel;
    cache_pkg::rdata_sel_e       rdata_sel;
    logic                        hit_evt;
    logic                        miss_evt;
    logic                        wback_evt;

    cache_datapath datapath_i (.*);

    cache_control control_i (.*);

    // Statistics only. Nothing feeds back into the cache.
    cache_apb_regs apb_regs_i (.*);

endmodule

//--- verif/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    assert property (@(posedge clk) disable iff (rst) mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp raised with no request pending");

    assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    // Physical requests hold until answered.
    assert property (@(posedge clk) disable iff (rst) pmem_read && !pmem_resp |=> pmem_read)
        else $error("pmem_read dropped before pmem_resp");

    assert property (@(posedge clk) disable iff (rst) pmem_write && !pmem_resp |=> pmem_write)
        else $error("pmem_write dropped before pmem_resp");

    assert property (@(posedge clk) rst |=> !mem_resp && !pmem_read && !pmem_write)
        else $error("handshake outputs not low after reset");

endmodule

bind cache_top cache_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp)
);

//--- verif/cache_tb.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_tb;

    logic                       clk = 1'b0;
    logic                       rst;
    logic [31:0]                mem_address;
    logic                       mem_read, mem_write, mem_resp;
    logic [`CACHE_MASK_W-1:0]   mem_byte_enable;
    logic [`CACHE_LINE_W-1:0]   mem_wdata, mem_rdata;
    logic [31:0]                pmem_address;
    logic                       pmem_read, pmem_write, pmem_resp;
    logic [`CACHE_LINE_W-1:0]   pmem_wdata, pmem_rdata;
    logic                       psel, penable, pwrite;
    logic [31:0]                paddr, pwdata, prdata;

    // Model state. The byte image is kept per line.
    logic [`CACHE_LINE_W-1:0]   ref_img [bit [31:0]];
    logic [`CACHE_LINE_W-1:0]   pmem_store [bit [31:0]];
    logic [`CACHE_TAG_W-1:0]    m_tag [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     m_valid [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]     m_dirty [`CACHE_SETS];
    logic [2:0]                 m_plru [`CACHE_SETS];
    int unsigned                n_hits, n_misses, n_wbacks;
    logic                       cnt_en;
    logic                       exp_hit, exp_wb;
    logic [31:0]                exp_wb_addr;
    logic [31:0]                apb_rd;

    cache_top cache_top_i (.*);

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        fail_run();
    endtask

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    // Power-on contents, unique per line address.
    function automatic logic [255:0] init_line(input logic [31:0] a);
        logic [255:0] l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = a ^ (32'h9E37_79B9 * 32'(i + 1)) ^ {a[7:0], a[31:8]};
        end
        return l;
    endfunction

    function automatic logic [255:0] ref_line(input logic [31:0] a);
        return ref_img.exists(a) ? ref_img[a] : init_line(a);
    endfunction

    function automatic logic [255:0] pmem_line(input logic [31:0] a);
        return pmem_store.exists(a) ? pmem_store[a] : init_line(a);
    endfunction

    // ########################################################################
    // Reference model of one CPU access.
    // ########################################################################

    task automatic model_access(input logic [31:0] addr, input logic wr,
                                input logic [31:0] be, input logic [255:0] wd);
        cache_pkg::cache_addr_u a;
        logic [255:0] l;
        logic [1:0]   way;
        int           s;
        a.raw   = addr;
        s       = int'(a.f.index);
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        way     = 2'd0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a.f.tag) begin
                exp_hit = 1'b1;
                way     = 2'(w);
            end
        end
        if (!exp_hit) begin
            if (m_plru[s][0]) begin
                way = m_plru[s][1] ? 2'd0 : 2'd1;
            end else begin
                way = m_plru[s][2] ? 2'd2 : 2'd3;
            end
            exp_wb         = m_valid[s][way] && m_dirty[s][way];
            exp_wb_addr    = {m_tag[s][way], a.f.index, 5'd0};
            m_tag[s][way]   = a.f.tag;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
            if (cnt_en) begin
                n_misses++;
                if (exp_wb) begin
                    n_wbacks++;
                end
            end
        end else if (cnt_en) begin
            n_hits++;
        end
        case (way)
            2'd0:    m_plru[s] = {m_plru[s][2], 2'b00};
            2'd1:    m_plru[s] = {m_plru[s][2], 2'b10};
            2'd2:    m_plru[s] = {1'b0, m_plru[s][1], 1'b1};
            default: m_plru[s] = {1'b1, m_plru[s][1], 1'b1};
        endcase
        if (wr) begin
            l = ref_line({addr[31:5], 5'd0});
            for (int b = 0; b < `CACHE_MASK_W; b++) begin
                if (be[b]) begin
                    l[b*8 +: 8] = wd[b*8 +: 8];
                end
            end
            ref_img[{addr[31:5], 5'd0}] = l;
            m_dirty[s][way] = 1'b1;
        end
    endtask

    // One random request, with the memory answering behind it.
    task automatic cpu_access(input logic wr);
        cache_pkg::cache_addr_u a;
        logic [31:0]  line;
        logic [255:0] wd;
        logic [31:0]  be;
        int           cycles;
        int           delay;
        logic         pending, wb_done, fill_done;
        a.f.tag    = 23'h0_1234 + 23'($urandom_range(5, 0)) * 23'h2B1;  // Six tags per set.
        a.f.index  = 4'($urandom);
        a.f.offset = 5'($urandom);
        be         = $urandom;
        for (int i = 0; i < 8; i++) begin
            wd[i*32 +: 32] = $urandom;
        end
        line = {a.raw[31:5], 5'd0};
        model_access(a.raw, wr, be, wd);
        mem_address     = a.raw;
        mem_read        = !wr;
        mem_write       = wr;
        mem_byte_enable = be;
        mem_wdata       = wd;
        cycles    = 0;
        delay     = 0;
        pending   = 1'b0;
        wb_done   = 1'b0;
        fill_done = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            pmem_resp = 1'b0;
            assert (cycles <= 200) else report_failure("timed out waiting for mem_resp");
            if (!mem_resp && (pmem_read || pmem_write)) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $urandom_range(5, 1);
                end
                delay--;
                if (delay == 0) begin
                    pending   = 1'b0;
                    pmem_resp = 1'b1;
                    if (pmem_write) begin
                        assert (exp_wb && !fill_done)
                            else report_failure("write-back not expected at this point");
                        check_value("pmem_address", 256'(exp_wb_addr), 256'(pmem_address));
                        check_value("pmem_wdata", ref_line(exp_wb_addr), pmem_wdata);
                        pmem_store[pmem_address] = pmem_wdata;
                        wb_done = 1'b1;
                    end else begin
                        assert (wb_done == exp_wb)
                            else report_failure("fill started before the write-back");
                        check_value("pmem_address", 256'(line), 256'(pmem_address));
                        pmem_rdata = pmem_line(pmem_address);
                        fill_done  = 1'b1;
                    end
                end
            end
        end while (!mem_resp);
        if (exp_hit) begin
            assert (cycles == 2)
                else report_failure($sformatf("hit answered after %0d cycles", cycles));
        end else begin
            assert (cycles > 2) else report_failure("miss answered with hit latency");
        end
        assert (fill_done == !exp_hit) else report_failure("fill does not match hit or miss");
        assert (wb_done == exp_wb) else report_failure("write-back missing");
        if (!wr) begin
            check_value("mem_rdata", ref_line(line), mem_rdata);
        end
        @(negedge clk);   // Request held through the response edge.
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            output logic [31:0] rd);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        rd      = prdata;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_counters();
        logic [31:0] rd;
        apb_xfer(1'b0, `CACHE_REG_HITS, 32'd0, rd);
        check_value("prdata HITS", 256'(n_hits), 256'(rd));
        apb_xfer(1'b0, `CACHE_REG_MISSES, 32'd0, rd);
        check_value("prdata MISSES", 256'(n_misses), 256'(rd));
        apb_xfer(1'b0, `CACHE_REG_WBACKS, 32'd0, rd);
        check_value("prdata WBACKS", 256'(n_wbacks), 256'(rd));
    endtask

    // ########################################################################
    // Test sequence.
    // ########################################################################

    initial begin
        void'($urandom(60355));
        rst             = 1'b1;
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        pmem_rdata      = '0;
        pmem_resp       = 1'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_plru[s]  = 3'b000;
        end
        cnt_en   = 1'b1;
        n_hits   = 0;
        n_misses = 0;
        n_wbacks = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        repeat (400) cpu_access(1'($urandom));
        check_counters();

        // Stop counting, then clear.
        apb_xfer(1'b1, `CACHE_REG_CTRL, 32'h0, apb_rd);
        cnt_en = 1'b0;
        apb_xfer(1'b1, `CACHE_REG_CTRL, 32'h2, apb_rd);
        n_hits   = 0;
        n_misses = 0;
        n_wbacks = 0;
        apb_xfer(1'b0, `CACHE_REG_CTRL, 32'd0, apb_rd);
        check_value("prdata CTRL", 256'({31'd0, cnt_en}), 256'(apb_rd));  // Clear bit reads 0.
        check_counters();
        repeat (20) cpu_access(1'($urandom));
        check_counters();

        apb_xfer(1'b1, `CACHE_REG_CTRL, 32'h1, apb_rd);
        cnt_en = 1'b1;
        apb_xfer(1'b0, `CACHE_REG_CTRL, 32'd0, apb_rd);
        check_value("prdata CTRL", 256'({31'd0, cnt_en}), 256'(apb_rd));
        repeat (40) cpu_access(1'($urandom));
        check_counters();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+design
design/cache_pkg.sv
design/cache_data_array.sv
design/cache_datapath.sv
design/cache_control.sv
design/cache_apb_regs.sv
design/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cache_tb --Mdir obj_dir -o cache_sim \
    -f list.f

./obj_dir/cache_sim 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
